/* compile.f */
source/vld_cfg_pkg.sv
source/vld_if_pkg.sv
source/vld_seq_fsm.sv
source/vld_elem_counter.sv
source/vld_addr_gen.sv
source/vld_scoreboard.sv
source/vld_scratchpad.sv
source/vld_top.sv
bench/vld_mem_model.sv
bench/vld_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the vector load engine testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --top-module vld_tb -f compile.f \
    --Mdir "$BUILD_DIR" -o vld_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/vld_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

/* bench/vld_tb.sv */
/* Load engine testbench
   Unit-strided, strided and random loads against a random memory, checked by assertions */
`timescale 1ns/1ps
`default_nettype none

module vld_tb;

    import vld_cfg_pkg::*;
    import vld_if_pkg::*;

    localparam int          RESET_CYCLES     = 10;
    localparam int          NUM_RANDOM       = 4;
    localparam int          NUM_INSTR        = 2 + NUM_RANDOM;
    localparam int          CYCLES_PER_INSTR = 200;
    localparam logic [31:0] RAND_SEED        = 32'ha860;
    localparam elem_t       DATA_KEY         = 32'h5a5a_0000;

    typedef logic [255:0] report_t;

    logic       clk;
    logic       rstn;
    logic       instr_valid;
    ld_instr_t  instr;
    logic       instr_ready;
    logic       req_en;
    mem_req_t   req_o;
    logic       grant;
    logic       resp_valid;
    mem_resp_t  resp;
    logic       wb_req;
    wb_t        wb_o;
    logic       busy;

    // Reference state of the instruction in flight
    ld_instr_t        cur_ins;
    logic             have_instr;
    int               req_count;
    int               wb_count;
    logic [VREGS-1:0] loops_done;
    logic             hold_prev;   // Request waited without a grant
    mem_req_t         req_prev;
    logic             acc_prev;

    logic       accept;
    vreg_idx_t  wb_loop;
    int         loops_exp;
    lane_mask_t exp_en;
    row_data_t  exp_row;
    row_data_t  act_row;
    logic [3:0] status_bits;

    always #2 clk = ~clk;

    vld_top u_vld_top (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .instr_ready_o (instr_ready),
        .req_en_o      (req_en),
        .req_o         (req_o),
        .grant_i       (grant),
        .resp_valid_i  (resp_valid),
        .resp_i        (resp),
        .wb_req_o      (wb_req),
        .wb_o          (wb_o),
        .busy_o        (busy)
    );

    vld_mem_model u_mem (
        .clk_i        (clk),
        .rstn_i       (rstn),
        .req_en_i     (req_en),
        .req_i        (req_o),
        .grant_o      (grant),
        .resp_valid_o (resp_valid),
        .resp_o       (resp)
    );

    // ========================================================================
    // Expected values from the load rules
    // ========================================================================
    function automatic lane_mask_t lanes_expect(vl_t vl, vreg_idx_t loop);
        lane_mask_t en;
        int         left;
        left = int'(vl) - VLANES * int'(loop);
        for (int i = 0; i < VLANES; i++) en[i] = (i < left);
        return en;
    endfunction

    // Element i of loop k sits at base + (8k + i) * step
    function automatic row_data_t row_expect(ld_instr_t ins, vreg_idx_t loop);
        row_data_t row;
        addr_t     step;
        addr_t     elem_idx;
        step = (ins.op == MEM_STRIDED) ? ins.stride : addr_t'(ELEM_BYTES);
        for (int i = 0; i < VLANES; i++) begin
            elem_idx = addr_t'(VLANES * int'(loop) + i);
            row[i]   = (ins.base + elem_idx * step) ^ DATA_KEY;
        end
        return row;
    endfunction

    function automatic row_data_t mask_row(row_data_t row, lane_mask_t en);
        row_data_t masked;
        for (int i = 0; i < VLANES; i++) masked[i] = en[i] ? row[i] : '0;
        return masked;
    endfunction

    assign accept      = instr_valid && instr_ready;
    assign wb_loop     = wb_o.vreg - cur_ins.dst;   // Wraps like the register number
    assign loops_exp   = (int'(cur_ins.vl) + VLANES - 1) / VLANES;
    assign exp_en      = lanes_expect(cur_ins.vl, wb_loop);
    assign exp_row     = mask_row(row_expect(cur_ins, wb_loop), exp_en);
    assign act_row     = mask_row(wb_o.data, wb_o.en);
    assign status_bits = {instr_ready, req_en, wb_req, busy};

    always @(posedge clk) begin
        hold_prev <= req_en && !grant;
        req_prev  <= req_o;
        acc_prev  <= accept;
        if (accept) begin
            cur_ins    <= instr;
            have_instr <= 1'b1;
            req_count  <= 0;
            wb_count   <= 0;
            loops_done <= '0;
        end else begin
            if (req_en && grant) req_count <= req_count + 1;
            if (wb_req) begin
                wb_count            <= wb_count + 1;
                loops_done[wb_loop] <= 1'b1;
            end
        end
    end

    task automatic report_mismatch(input string test, input report_t exp, input report_t act);
        $display("ERROR: %s expected %0h actual %0h", test, exp, act);
        $display("Test failed");
        $fatal(1, "Check %s did not hold", test);
    endtask

    // ========================================================================
    // Checks
    // ========================================================================
    a_reset_state: assert property (@(posedge clk) $rose(rstn) |-> status_bits == 4'b1000)
        else report_mismatch("reset_state", report_t'(4'b1000), report_t'($sampled(status_bits)));

    a_busy_inverse: assert property (@(posedge clk) disable iff (!rstn) busy == !instr_ready)
        else report_mismatch("busy_inverse", report_t'(!$sampled(instr_ready)),
                             report_t'($sampled(busy)));

    a_first_request: assert property (@(posedge clk) disable iff (!rstn) acc_prev |-> req_en)
        else report_mismatch("accept_to_request", report_t'(1'b1), report_t'($sampled(req_en)));

    a_backpressure: assert property (@(posedge clk) disable iff (!rstn)
        hold_prev |-> req_en && (req_o == req_prev))
        else report_mismatch("backpressure", report_t'({1'b1, $sampled(req_prev)}),
                             report_t'({$sampled(req_en), $sampled(req_o)}));

    a_wb_loop: assert property (@(posedge clk) disable iff (!rstn)
        wb_req |-> int'(wb_loop) < loops_exp)
        else report_mismatch("writeback_loop", report_t'($sampled(loops_exp)),
                             report_t'($sampled(wb_loop)));

    a_wb_once: assert property (@(posedge clk) disable iff (!rstn)
        wb_req |-> !loops_done[wb_loop])
        else report_mismatch("writeback_once", report_t'(1'b0), report_t'(1'b1));

    a_wb_enable: assert property (@(posedge clk) disable iff (!rstn)
        wb_req |-> wb_o.en == exp_en)
        else report_mismatch("writeback_enable", report_t'($sampled(exp_en)),
                             report_t'($sampled(wb_o.en)));

    a_wb_data: assert property (@(posedge clk) disable iff (!rstn)
        wb_req |-> act_row == exp_row)
        else report_mismatch("writeback_data", report_t'($sampled(exp_row)),
                             report_t'($sampled(act_row)));

    a_idle_quiet: assert property (@(posedge clk) disable iff (!rstn)
        instr_ready |-> !req_en && !wb_req)
        else report_mismatch("idle_quiet", report_t'(2'b00),
                             report_t'({$sampled(req_en), $sampled(wb_req)}));

    // Next instruction only once the previous one has fully written back
    a_single_instr: assert property (@(posedge clk) disable iff (!rstn)
        accept && have_instr |-> (wb_count == loops_exp) && (req_count == int'(cur_ins.vl)))
        else report_mismatch("single_instruction", report_t'($sampled(loops_exp)),
                             report_t'($sampled(wb_count)));

    a_wb_count: assert property (@(posedge clk) disable iff (!rstn)
        $rose(instr_ready) && have_instr |-> wb_count == loops_exp)
        else report_mismatch("writeback_count", report_t'($sampled(loops_exp)),
                             report_t'($sampled(wb_count)));

    a_req_count: assert property (@(posedge clk) disable iff (!rstn)
        $rose(instr_ready) && have_instr |-> req_count == int'(cur_ins.vl))
        else report_mismatch("request_count", report_t'($sampled(cur_ins.vl)),
                             report_t'($sampled(req_count)));

    // ========================================================================
    // Stimulus
    // ========================================================================
    function automatic ld_instr_t make_instr(addr_t base, addr_t stride, vl_t vl,
                                             vreg_idx_t dst, mem_op_e op);
        return ld_instr_t'{base: base, stride: stride, vl: vl, dst: dst, op: op};
    endfunction

    function automatic ld_instr_t random_instr();
        ld_instr_t ins;
        ins.base   = addr_t'($urandom) & ~addr_t'(3);     // Word aligned
        ins.stride = addr_t'($urandom_range(64, 0) * 4);
        ins.vl     = vl_t'($urandom_range(40, 1));
        ins.dst    = vreg_idx_t'($urandom_range(31, 0));  // High dst wraps around
        ins.op     = ($urandom_range(1, 0) == 1) ? MEM_STRIDED : MEM_UNIT;
        return ins;
    endfunction

    // Valid stays high until the engine takes the instruction
    task automatic send_instr(input ld_instr_t ins);
        instr_valid <= 1'b1;
        instr       <= ins;
        @(posedge clk);
        while (!instr_ready) @(posedge clk);
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        clk         = 1'b0;
        rstn        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        send_instr(make_instr(32'h0000_1000, 32'h0, 9'd8, 5'd5, MEM_UNIT));
        send_instr(make_instr(32'h0002_0040, 32'd12, 9'd20, 5'd10, MEM_STRIDED));
        for (int n = 0; n < NUM_RANDOM; n++) send_instr(random_instr());

        instr_valid <= 1'b0;
        @(posedge clk);
        while (!instr_ready) @(posedge clk);
        repeat (2) @(posedge clk);   // Let the end-of-instruction checks fire
        $display("Test passed");
        $finish;
    end

    // Watchdog
    initial begin
        repeat (RESET_CYCLES + NUM_INSTR * CYCLES_PER_INSTR) @(posedge clk);
        $display("Timeout: the loads did not complete within the allowed cycles");
        $display("Test failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

/* bench/vld_mem_model.sv */
/* Memory responder for the load engine
   Random grant level, answers each granted ticket after a random delay */
`timescale 1ns/1ps
`default_nettype none

module vld_mem_model (
    input  wire logic                 clk_i,
    input  wire logic                 rstn_i,
    input  wire logic                 req_en_i,
    input  wire vld_if_pkg::mem_req_t req_i,
    output logic                      grant_o,
    output logic                      resp_valid_o,
    output vld_if_pkg::mem_resp_t     resp_o
);

    import vld_cfg_pkg::*;
    import vld_if_pkg::*;

    localparam elem_t DATA_KEY = 32'h5a5a_0000;   // Data is address XOR this key

    mem_resp_t held_q [$];   // Granted, answer not yet sent
    int        due_q [$];    // Cycle from which each held answer may go out
    int        cyc;

    always @(posedge clk_i or negedge rstn_i) begin : respond
        int idx;
        if (!rstn_i) begin
            grant_o      <= 1'b0;
            resp_valid_o <= 1'b0;
            resp_o       <= '0;
            held_q.delete();
            due_q.delete();
            cyc = 0;
        end else begin
            cyc = cyc + 1;
            grant_o <= ($urandom_range(3, 0) != 0);   // About three cycles in four
            if (req_en_i && grant_o) begin
                held_q.push_back(mem_resp_t'{ticket: req_i.ticket,
                                             data: req_i.addr ^ DATA_KEY});
                due_q.push_back(cyc + int'($urandom_range(4, 1)));
            end
            // Short delays overtake long ones, so answers leave out of order
            idx = -1;
            for (int i = 0; i < held_q.size(); i++) begin
                if (idx < 0 && due_q[i] <= cyc) idx = i;
            end
            resp_valid_o <= (idx >= 0);
            if (idx >= 0) begin
                resp_o <= held_q[idx];
                held_q.delete(idx);
                due_q.delete(idx);
            end
        end
    end

endmodule

`default_nettype wire

/* source/vld_top.sv */
/* Vector load engine top level
   Connects sequencer, element counter, address generator, scoreboard and scratchpad */
`timescale 1ns/1ps
`default_nettype none

module vld_top (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    // Instruction input
    input  wire logic                  instr_valid_i,
    input  wire vld_if_pkg::ld_instr_t instr_i,
    output logic                       instr_ready_o,
    // Memory requests
    output logic                       req_en_o,
    output vld_if_pkg::mem_req_t       req_o,
    input  wire logic                  grant_i,
    // Memory responses
    input  wire logic                  resp_valid_i,
    input  wire vld_if_pkg::mem_resp_t resp_i,
    // Register file writeback
    output logic                       wb_req_o,
    output vld_if_pkg::wb_t            wb_o,
    output logic                       busy_o
);

    import vld_cfg_pkg::*;
    import vld_if_pkg::*;

    logic       accept;
    logic       start_loop;
    logic       issue_en;
    logic       step;          // Request taken this cycle
    logic       req_pending;
    logic       row_pending;
    logic       other_active;
    logic       sb_idle;
    logic       last_loop;
    logic       wb_row;
    ticket_t    ticket;
    vreg_idx_t  loop;
    lane_mask_t loop_mask;
    addr_t      addr;
    vreg_idx_t  wb_reg;
    lane_mask_t wb_en;
    row_data_t  wb_data;

    assign req_en_o = issue_en & req_pending;
    assign step     = req_en_o & grant_i;
    assign req_o    = '{addr: addr, ticket: ticket};
    assign wb_o     = '{vreg: wb_reg, en: wb_en, data: wb_data};

    vld_seq_fsm u_fsm (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .instr_valid_i  (instr_valid_i),
        .sb_idle_i      (sb_idle),
        .row_pending_i  (row_pending),
        .other_active_i (other_active),
        .last_loop_i    (last_loop),
        .instr_ready_o  (instr_ready_o),
        .accept_o       (accept),
        .start_loop_o   (start_loop),
        .issue_en_o     (issue_en),
        .busy_o         (busy_o)
    );

    vld_elem_counter u_counter (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .accept_i     (accept),
        .start_loop_i (start_loop),
        .step_i       (step),
        .instr_vl_i   (instr_i.vl),
        .ticket_o     (ticket),
        .loop_o       (loop),
        .last_loop_o  (last_loop),
        .loop_mask_o  (loop_mask)
    );

    vld_addr_gen u_addr (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .accept_i (accept),
        .step_i   (step),
        .instr_i  (instr_i),
        .addr_o   (addr)
    );

    vld_scoreboard u_sb (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .accept_i       (accept),
        .start_loop_i   (start_loop),
        .step_i         (step),
        .ticket_i       (ticket),
        .loop_i         (loop),
        .loop_mask_i    (loop_mask),
        .dst_i          (instr_i.dst),
        .resp_valid_i   (resp_valid_i),
        .resp_ticket_i  (resp_i.ticket),
        .req_pending_o  (req_pending),
        .row_pending_o  (row_pending),
        .other_active_o (other_active),
        .idle_o         (sb_idle),
        .wb_req_o       (wb_req_o),
        .wb_row_o       (wb_row),
        .wb_reg_o       (wb_reg),
        .wb_en_o        (wb_en)
    );

    vld_scratchpad u_pad (
        .clk_i        (clk_i),
        .resp_valid_i (resp_valid_i),
        .resp_i       (resp_i),
        .rd_row_i     (wb_row),
        .rd_data_o    (wb_data)
    );

endmodule

`default_nettype wire

/* source/vld_scratchpad.sv */
/* Load scratchpad
   Two rows of elements, filled by response ticket and read a full row at a time */
`timescale 1ns/1ps
`default_nettype none

module vld_scratchpad (
    input  wire logic                  clk_i,
    input  wire logic                  resp_valid_i,
    input  wire vld_if_pkg::mem_resp_t resp_i,
    input  wire logic                  rd_row_i,    // Row being written back
    output vld_cfg_pkg::row_data_t     rd_data_o
);

    import vld_cfg_pkg::*;

    // ========================================================================
    // Storage
    // ========================================================================
    row_data_t pad_q [2];

    // Responses arrive in any order, the ticket picks the slot
    always_ff @(posedge clk_i) begin
        if (resp_valid_i) begin
            pad_q[resp_i.ticket.row][resp_i.ticket.lane] <= resp_i.data;
        end
    end

    // Whole row straight to the register file write port
    assign rd_data_o = pad_q[rd_row_i];

endmodule

`default_nettype wire

/* source/vld_scoreboard.sv */
/* Lane scoreboard
   Pending, active and served masks per row, row destinations and writeback choice */
`timescale 1ns/1ps
`default_nettype none

module vld_scoreboard (
    input  wire logic                   clk_i,
    input  wire logic                   rstn_i,
    input  wire logic                   accept_i,
    input  wire logic                   start_loop_i,
    input  wire logic                   step_i,
    input  wire vld_if_pkg::ticket_t    ticket_i,      // Row and lane now requesting
    input  wire vld_cfg_pkg::vreg_idx_t loop_i,
    input  wire vld_cfg_pkg::lane_mask_t loop_mask_i,
    input  wire vld_cfg_pkg::vreg_idx_t dst_i,
    input  wire logic                   resp_valid_i,
    input  wire vld_if_pkg::ticket_t    resp_ticket_i,
    output logic                        req_pending_o,
    output logic                        row_pending_o,
    output logic                        other_active_o,
    output logic                        idle_o,
    output logic                        wb_req_o,
    output logic                        wb_row_o,
    output vld_cfg_pkg::vreg_idx_t      wb_reg_o,
    output vld_cfg_pkg::lane_mask_t     wb_en_o
);

    import vld_cfg_pkg::*;

    lane_mask_t [1:0] pending_q;   // Not yet requested
    lane_mask_t [1:0] active_q;    // Belong to the loop held in the row
    lane_mask_t [1:0] served_q;    // Response received
    vreg_idx_t        row_dst_q [2];
    vreg_idx_t        dst_q;
    logic             cur_row;
    logic             new_row;
    logic [1:0]       row_done;

    assign cur_row = ticket_i.row;
    assign new_row = ~cur_row;

    // ========================================================================
    // Status towards the sequencer
    // ========================================================================
    assign req_pending_o  = pending_q[cur_row][ticket_i.lane];
    assign row_pending_o  = |pending_q[cur_row];
    assign other_active_o = |active_q[new_row];
    assign idle_o         = ~|pending_q & ~|active_q;

    // ========================================================================
    // Writeback selection, row 0 first
    // ========================================================================
    always_comb begin
        for (int r = 0; r < 2; r++) begin
            row_done[r] = (served_q[r] == active_q[r]) && |active_q[r];
        end
    end

    assign wb_req_o = |row_done;
    assign wb_row_o = ~row_done[0];
    assign wb_reg_o = row_dst_q[wb_row_o];
    assign wb_en_o  = active_q[wb_row_o];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pending_q <= '0;
            active_q  <= '0;
            served_q  <= '0;
        end else if (accept_i) begin
            pending_q <= {lane_mask_t'(0), loop_mask_i};  // Loop 0 always in row 0
            active_q  <= {lane_mask_t'(0), loop_mask_i};
            served_q  <= '0;
        end else begin
            for (int r = 0; r < 2; r++) begin
                if (start_loop_i && new_row == r[0]) pending_q[r] <= loop_mask_i;
                else if (step_i && cur_row == r[0]) pending_q[r][ticket_i.lane] <= 1'b0;

                if (wb_req_o && wb_row_o == r[0]) active_q[r] <= '0;
                else if (start_loop_i && new_row == r[0]) active_q[r] <= loop_mask_i;

                if (start_loop_i && new_row == r[0]) served_q[r] <= '0;
                else if (resp_valid_i && resp_ticket_i.row == r[0])
                    served_q[r][resp_ticket_i.lane] <= 1'b1;
            end
        end
    end

    // Destination of each row is dst plus the loop it holds
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            dst_q        <= dst_i;
            row_dst_q[0] <= dst_i;
        end else if (start_loop_i) begin
            row_dst_q[new_row] <= dst_q + loop_i + 1'b1;
        end
    end

    // Memory only answers lanes that were requested in the current loop
    a_resp_active: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_i |-> active_q[resp_ticket_i.row][resp_ticket_i.lane]
                         && !pending_q[resp_ticket_i.row][resp_ticket_i.lane]);

endmodule

`default_nettype wire

/* source/vld_addr_gen.sv */
/* Request address generator
   Holds the element address and steps it by element size or by stride */
`timescale 1ns/1ps
`default_nettype none

module vld_addr_gen (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,
    input  wire logic                  accept_i,
    input  wire logic                  step_i,   // Request granted
    input  wire vld_if_pkg::ld_instr_t instr_i,
    output vld_cfg_pkg::addr_t         addr_o
);

    import vld_cfg_pkg::*;
    import vld_if_pkg::*;

    addr_t   addr_q;
    addr_t   stride_q;
    mem_op_e op_q;
    addr_t   step_amt;

    assign step_amt = (op_q == MEM_STRIDED) ? stride_q : addr_t'(ELEM_BYTES);
    assign addr_o   = addr_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            addr_q   <= '0;
            stride_q <= '0;
            op_q     <= MEM_UNIT;
        end else if (accept_i) begin
            addr_q   <= instr_i.base;     // Element 0 of loop 0
            stride_q <= instr_i.stride;
            op_q     <= instr_i.op;
        end else if (step_i) begin
            addr_q   <= addr_q + step_amt;
        end
    end

    // A reload never lands on a granted request
    a_no_step_on_load: assert property (@(posedge clk_i) disable iff (!rstn_i)
        accept_i |-> !step_i);

endmodule

`default_nettype wire

/* source/vld_elem_counter.sv */
/* Element counter
   Lane pointer, current row and loop number, with the lane mask of the next loop */
`timescale 1ns/1ps
`default_nettype none

module vld_elem_counter (
    input  wire logic                 clk_i,
    input  wire logic                 rstn_i,
    input  wire logic                 accept_i,
    input  wire logic                 start_loop_i,
    input  wire logic                 step_i,
    input  wire vld_cfg_pkg::vl_t     instr_vl_i,
    output vld_if_pkg::ticket_t       ticket_o,
    output vld_cfg_pkg::vreg_idx_t    loop_o,
    output logic                      last_loop_o,
    output vld_cfg_pkg::lane_mask_t   loop_mask_o
);

    import vld_cfg_pkg::*;

    lane_idx_t lane_q;
    logic      row_q;
    vreg_idx_t loop_q;
    vl_t       vl_q;
    vl_t       next_base;   // First element of the following loop
    vl_t       remain;

    // Widen before the add so loop 31 still yields 256
    assign next_base = (vl_t'(loop_q) + 1'b1) << LANE_W;
    assign remain    = accept_i ? instr_vl_i : vl_q - next_base;

    // All lanes, or only the low lanes still left
    always_comb begin
        for (int i = 0; i < VLANES; i++) begin
            loop_mask_o[i] = (remain > vl_t'(i));
        end
    end

    assign last_loop_o = (next_base >= vl_q);
    assign loop_o      = loop_q;
    assign ticket_o    = '{row: row_q, lane: lane_q};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            lane_q <= '0;
            row_q  <= 1'b0;
            loop_q <= '0;
            vl_q   <= '0;
        end else if (accept_i) begin
            lane_q <= '0;
            row_q  <= 1'b0;
            loop_q <= '0;
            vl_q   <= instr_vl_i;
        end else if (start_loop_i) begin
            lane_q <= '0;
            row_q  <= ~row_q;         // Next register goes to the other row
            loop_q <= loop_q + 1'b1;
        end else if (step_i) begin
            lane_q <= lane_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/vld_seq_fsm.sv */
/* Load sequencer
   Steps through issue, row switching and drain for one instruction at a time */
`timescale 1ns/1ps
`default_nettype none

module vld_seq_fsm (
    input  wire logic clk_i,
    input  wire logic rstn_i,
    input  wire logic instr_valid_i,
    input  wire logic sb_idle_i,      // No lane pending or active
    input  wire logic row_pending_i,  // Current row still has lanes to request
    input  wire logic other_active_i, // Other row not yet written back
    input  wire logic last_loop_i,
    output logic      instr_ready_o,
    output logic      accept_o,
    output logic      start_loop_o,
    output logic      issue_en_o,
    output logic      busy_o
);

    // One-hot so a corrupted state stays visible
    typedef enum logic [3:0] {
        IDLE     = 4'b0001,
        ISSUE    = 4'b0010,
        WAIT_ROW = 4'b0100,
        DRAIN    = 4'b1000
    } state_e;

    state_e state_q;
    state_e state_d;

    assign instr_ready_o = (state_q == IDLE);
    assign busy_o        = ~instr_ready_o;
    assign accept_o      = instr_valid_i & instr_ready_o;
    assign issue_en_o    = (state_q == ISSUE);

    always_comb begin
        state_d      = state_q;
        start_loop_o = 1'b0;
        case (state_q)
            IDLE: if (accept_o) state_d = ISSUE;
            ISSUE: begin
                if (!row_pending_i) begin
                    if (last_loop_i) state_d = DRAIN;   // Only responses left
                    else if (!other_active_i) start_loop_o = 1'b1;
                    else state_d = WAIT_ROW;            // Other row still collecting
                end
            end
            WAIT_ROW: begin
                if (!other_active_i) begin
                    start_loop_o = 1'b1;
                    state_d      = ISSUE;
                end
            end
            DRAIN: if (sb_idle_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) state_q <= IDLE;
        else state_q <= state_d;
    end

    a_state_legal: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot(state_q));

endmodule

`default_nettype wire

/* source/vld_if_pkg.sv */
/* Vector load engine transaction types
   Instruction, memory request and response, and row writeback records */
`default_nettype none

package vld_if_pkg;

    import vld_cfg_pkg::*;

    // Addressing mode of a load
    typedef enum logic [1:0] {
        MEM_UNIT    = 2'd0,   // Step of one element
        MEM_STRIDED = 2'd1    // Step taken from the instruction
    } mem_op_e;

    // Request tag, names the scratchpad slot a response lands in
    typedef struct packed {
        logic      row;
        lane_idx_t lane;
    } ticket_t;

    // ========================================================================
    // Transactions
    // ========================================================================
    typedef struct packed {
        addr_t     base;      // Address of element 0
        addr_t     stride;    // Byte distance, strided mode only
        vl_t       vl;
        vreg_idx_t dst;       // First destination register
        mem_op_e   op;
    } ld_instr_t;

    typedef struct packed {
        addr_t   addr;
        ticket_t ticket;
    } mem_req_t;

    typedef struct packed {
        ticket_t ticket;
        elem_t   data;
    } mem_resp_t;

    // One register write with per-lane enable
    typedef struct packed {
        vreg_idx_t  vreg;
        lane_mask_t en;
        row_data_t  data;
    } wb_t;

endpackage

`default_nettype wire

/* source/vld_cfg_pkg.sv */
/* Vector load engine dimensions
   Lane, register and width constants with the types derived from them */
`default_nettype none

package vld_cfg_pkg;

    // ========================================================================
    // Dimensions
    // ========================================================================
    localparam int VLANES     = 8;                 // Lanes per vector register
    localparam int VREGS      = 32;                // Architectural vector registers
    localparam int ELEM_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int ELEM_BYTES = ELEM_W / 8;        // Unit-strided address step

    localparam int LANE_W = $clog2(VLANES);
    localparam int VREG_W = $clog2(VREGS);
    localparam int VL_W   = $clog2(VLANES * VREGS) + 1; // Covers vl of 0 to 256

    // ========================================================================
    // Derived types
    // ========================================================================
    typedef logic [LANE_W-1:0] lane_idx_t;
    typedef logic [VLANES-1:0] lane_mask_t;        // One bit per lane
    typedef logic [VREG_W-1:0] vreg_idx_t;
    typedef logic [VL_W-1:0]   vl_t;
    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [ADDR_W-1:0] addr_t;

    // Full destination row, lane 0 in the low bits
    typedef logic [VLANES-1:0][ELEM_W-1:0] row_data_t;

endpackage

`default_nettype wire
